/* run.sh */
#!/usr/bin/env bash
# Build and run the bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
   --top-module axi4_to_ahb_tb -f src.f -o sim_tb

# The simulation exits nonzero on failure, the log decides the result
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: PASS" sim.log; then
   exit 0
else
   exit 1
fi

/* source/ahb_byte_planner.sv */
// ******************************
// Strobe planner
// Aligned size and offset of a write, or the
// next byte to send for a scattered strobe
// ******************************
`timescale 1ns/1ps
`include "axi_ahb_settings.svh"

module ahb_byte_planner import axi_ahb_pkg::*; (
   input  logic [2:0]             size,
   input  logic [`BUS_STRB_W-1:0] byteen,
   input  logic [2:0]             ptr,
   input  logic                   advance,
   output byte_plan_t             plan
);

   logic [1:0] pat_size;
   logic       narrow, aligned;
   logic       found;
   logic [2:0] low, nxt;

   // Doubleword strobes that map to one AHB transfer
   always_comb begin
      case (byteen)
         8'hff:                      pat_size = 2'd3;
         8'h0f, 8'hf0:               pat_size = 2'd2;
         8'h03, 8'h0c, 8'h30, 8'hc0: pat_size = 2'd1;
         default:                    pat_size = 2'd0;
      endcase
   end

   assign narrow  = (size < 3'd3);             // Byte, half and word
   assign aligned = narrow | (pat_size != 2'd0);

   // Scan downward so the lowest hit wins
   always_comb begin
      found = 1'b0;
      low   = 3'd0;
      nxt   = 3'd7;
      for (int j = `BUS_STRB_W - 1; j >= 0; j--) begin
         if (byteen[j]) begin
            low = 3'(j);
         end
         if (byteen[j] && (advance ? (j > int'(ptr)) : (j >= int'(ptr)))) begin
            nxt   = 3'(j);
            found = 1'b1;
         end
      end
   end

   always_comb begin
      plan.aligned  = aligned;
      plan.size     = !aligned ? 2'd0 : (narrow ? size[1:0] : pat_size);
      plan.offset   = low;                     // First lane of the transfer
      plan.next_ptr = nxt;
      plan.last     = ~found;
   end

endmodule

/* source/ahb_xfer_fsm.sv */
// ******************************
// AHB transfer engine
// One-entry command buffer and the FSM that
// runs reads, writes and byte splits on AHB
// ******************************
`timescale 1ns/1ps
`include "axi_ahb_settings.svh"

module ahb_xfer_fsm import axi_ahb_pkg::*; (
   input  logic                   ahbm_clk,
   input  logic                   rst,
   input  logic                   cmd_valid,
   input  bus_cmd_t               cmd,
   output logic                   cmd_ready,
   output ahb_req_t               ahb,
   output logic [`BUS_DATA_W-1:0] hwdata,
   input  logic [`BUS_DATA_W-1:0] hrdata,
   input  logic                   hready,
   input  logic                   hresp,
   input  logic                   bready,
   input  logic                   rready,
   output logic                   resp_load,
   output logic [`AXI_TAG_W-1:0]  resp_tag,
   output logic                   resp_write,
   output logic                   err_load,
   output logic                   err_in,
   output logic                   resp_fire,
   output xfer_state_e            state,
   output logic [`BUS_DATA_W-1:0] hrdata_q,
   output logic [`BUS_DATA_W-1:0] buf_data
);

   xfer_state_e nxt_state;
   logic        state_en, slave_ready;
   logic        buf_wr_en, data_wr_en;
   logic        bypass_en, trxn_done;
   logic        cmd_done, cmd_done_q;
   logic        ptr_en;
   logic [2:0]  ptr_d, ptr_q;
   logic [1:0]  htrans, htrans_q;
   logic        hready_q, hwrite_q, hresp_q;
   bus_cmd_t    buf_q, src;
   byte_plan_t  plan_in, plan_buf, src_plan;

   assign slave_ready = bready & rready;

   ahb_byte_planner u_plan_in (
      .size    (cmd.size),
      .byteen  (cmd.byteen),
      .ptr     (3'd0),
      .advance (1'b0),
      .plan    (plan_in)
   );

   ahb_byte_planner u_plan_buf (
      .size    (buf_q.size),
      .byteen  (buf_q.byteen),
      .ptr     (ptr_q),
      .advance (1'b1),                         // Step past the byte just sent
      .plan    (plan_buf)
   );

   // ******************************
   // Transfer FSM
   // ******************************
   always_comb begin
      nxt_state  = IDLE;
      state_en   = 1'b0;
      cmd_ready  = 1'b0;
      buf_wr_en  = 1'b0;
      data_wr_en = 1'b0;
      bypass_en  = 1'b0;
      trxn_done  = 1'b0;
      cmd_done   = 1'b0;
      ptr_en     = 1'b0;
      ptr_d      = ptr_q;
      resp_load  = 1'b0;
      err_load   = 1'b0;
      err_in     = 1'b0;
      resp_fire  = 1'b0;
      htrans     = `HTRANS_IDLE;
      case (state)
         IDLE: begin
            cmd_ready  = 1'b1;
            nxt_state  = cmd.write ? CMD_WR : CMD_RD;
            state_en   = cmd_valid;
            buf_wr_en  = cmd_valid;
            data_wr_en = cmd_valid & cmd.write;
            bypass_en  = cmd_valid;            // Address phase straight from the command
            ptr_en     = cmd_valid;
            ptr_d      = cmd.write ? plan_in.offset : cmd.addr[2:0];
            if (cmd_valid) htrans = `HTRANS_NONSEQ;
         end
         CMD_RD: begin
            nxt_state = DATA_RD;
            state_en  = hready_q & (htrans_q != `HTRANS_IDLE) & ~hwrite_q;
            cmd_done  = state_en;
            resp_load = state_en;
            ptr_d     = buf_q.addr[2:0];
            if (!state_en) htrans = `HTRANS_NONSEQ;
         end
         DATA_RD: begin
            nxt_state  = DONE;
            state_en   = hready_q | hresp_q;
            data_wr_en = state_en;             // Park read data for DONE
            err_in     = hresp_q;
            err_load   = state_en;
            resp_load  = state_en;
         end
         CMD_WR: begin
            nxt_state = DATA_WR;
            trxn_done = hready_q & hwrite_q & (htrans_q != `HTRANS_IDLE);
            state_en  = trxn_done;
            resp_load = trxn_done;
            ptr_en    = trxn_done;
            if (trxn_done) ptr_d = plan_buf.next_ptr;
            cmd_done  = trxn_done & (plan_buf.aligned | plan_buf.last);
            if (!(cmd_done | cmd_done_q)) htrans = `HTRANS_NONSEQ;
         end
         DATA_WR: begin
            state_en  = (cmd_done_q & hready_q) | hresp_q;
            cmd_ready = state_en & ~hresp_q & slave_ready;
            if (hresp_q | ~slave_ready) begin
               nxt_state = DONE;
            end else if (cmd_valid & cmd_ready) begin
               nxt_state = cmd.write ? CMD_WR : CMD_RD;
            end else begin
               nxt_state = IDLE;
            end
            err_in     = hresp_q;
            err_load   = state_en;
            buf_wr_en  = state_en & ((nxt_state == CMD_WR) | (nxt_state == CMD_RD));
            data_wr_en = buf_wr_en;
            bypass_en  = buf_wr_en & cmd.write;  // Next write overlaps this data phase
            resp_fire  = state_en & (nxt_state != DONE);
            trxn_done  = hready_q & hwrite_q & (htrans_q != `HTRANS_IDLE);
            cmd_done   = hresp_q | (trxn_done & (plan_buf.aligned | plan_buf.last));
            ptr_en     = trxn_done | bypass_en;
            if (bypass_en) begin
               ptr_d = plan_in.offset;
            end else if (trxn_done) begin
               ptr_d = plan_buf.next_ptr;
            end
            if (!(cmd_done | cmd_done_q) || bypass_en) htrans = `HTRANS_NONSEQ;
         end
         DONE: begin
            nxt_state = IDLE;
            state_en  = slave_ready;           // Held here under back-pressure
            err_load  = slave_ready;
            resp_fire = 1'b1;
         end
         default: state_en = 1'b1;
      endcase
   end

   always_ff @(posedge ahbm_clk) begin
      if (rst) begin
         state      <= IDLE;
         cmd_done_q <= 1'b0;
         ptr_q      <= 3'd0;
      end else begin
         if (state_en) state <= nxt_state;
         if (resp_fire) begin
            cmd_done_q <= 1'b0;
         end else if (cmd_done) begin
            cmd_done_q <= 1'b1;
         end
         if (ptr_en) ptr_q <= ptr_d;
      end
   end

   // Command buffer, wdata doubles as read data holder
   always_ff @(posedge ahbm_clk) begin
      if (buf_wr_en) begin
         buf_q.write  <= cmd.write;
         buf_q.tag    <= cmd.tag;
         buf_q.addr   <= cmd.addr;
         buf_q.size   <= cmd.size;
         buf_q.byteen <= cmd.byteen;
      end
      if (data_wr_en) buf_q.wdata <= (state == DATA_RD) ? hrdata_q : cmd.wdata;
   end

   // ******************************
   // AHB sampling and drive
   // ******************************
   always_ff @(posedge ahbm_clk) begin
      if (rst) begin
         hready_q <= 1'b0;
         htrans_q <= `HTRANS_IDLE;
         hwrite_q <= 1'b0;
         hresp_q  <= 1'b0;
      end else begin
         hready_q <= hready;
         htrans_q <= htrans;
         hwrite_q <= ahb.hwrite;
         hresp_q  <= hresp;
      end
   end

   always_ff @(posedge ahbm_clk) begin
      hrdata_q <= hrdata;
   end

   assign src      = bypass_en ? cmd : buf_q;
   assign src_plan = bypass_en ? plan_in : plan_buf;

   assign ahb.haddr  = {src.addr[`BUS_ADDR_W-1:3], ptr_d};
   assign ahb.hsize  = src.write ? {1'b0, src_plan.size} : src.size;
   assign ahb.htrans = htrans;
   assign ahb.hwrite = src.write;

   assign hwdata     = buf_q.wdata;
   assign buf_data   = buf_q.wdata;
   assign resp_tag   = buf_q.tag;
   assign resp_write = buf_q.write;

   // Planner output must give naturally aligned transfers
   ahb_aligned_a: assert property (@(posedge ahbm_clk) disable iff (rst)
      ahb.htrans[1] |-> (ahb.haddr[2:0] & ((3'd1 << ahb.hsize) - 3'd1)) == 3'd0);

   // Two-cycle AHB error response
   ahb_err_a: assert property (@(posedge ahbm_clk) disable iff (rst)
      hready && hresp |-> $past(!hready && hresp));

endmodule

/* source/axi4_to_ahb.sv */
// ******************************
// AXI4 slave to AHB-Lite master bridge
// Single-beat 64-bit transfers
// ******************************
`timescale 1ns/1ps
`include "axi_ahb_settings.svh"

module axi4_to_ahb import axi_ahb_pkg::*; (
   input  logic                   ahbm_clk,
   input  logic                   rst,
   input  logic                   awvalid,
   output logic                   awready,
   input  axi_aw_t                aw,
   input  logic                   wvalid,
   output logic                   wready,
   input  axi_w_t                 w,
   output logic                   bvalid,
   input  logic                   bready,
   output logic [`AXI_TAG_W-1:0]  bid,
   output logic [1:0]             bresp,
   input  logic                   arvalid,
   output logic                   arready,
   input  axi_ar_t                ar,
   output logic                   rvalid,
   input  logic                   rready,
   output logic [`AXI_TAG_W-1:0]  rid,
   output logic [1:0]             rresp,
   output logic [`BUS_DATA_W-1:0] rdata,
   output ahb_req_t               ahb,
   output logic [`BUS_DATA_W-1:0] hwdata,
   input  logic [`BUS_DATA_W-1:0] hrdata,
   input  logic                   hready,
   input  logic                   hresp
);

   logic                   cmd_valid, cmd_ready;
   bus_cmd_t               cmd;
   logic                   resp_load, resp_write, resp_fire;
   logic [`AXI_TAG_W-1:0]  resp_tag;
   logic                   err_load, err_in;
   xfer_state_e            state;
   logic [`BUS_DATA_W-1:0] hrdata_q, buf_data;

   axi_wr_gather u_wr_gather (
      .ahbm_clk, .rst,
      .awvalid, .awready, .aw,
      .wvalid, .wready, .w,
      .arvalid, .arready, .ar,
      .cmd_valid, .cmd_ready, .cmd
   );

   ahb_xfer_fsm u_xfer_fsm (
      .ahbm_clk, .rst,
      .cmd_valid, .cmd, .cmd_ready,
      .ahb, .hwdata, .hrdata, .hready, .hresp,
      .bready, .rready,
      .resp_load, .resp_tag, .resp_write,
      .err_load, .err_in, .resp_fire,
      .state, .hrdata_q, .buf_data
   );

   axi_resp_gen u_resp_gen (
      .ahbm_clk, .rst,
      .resp_load, .tag_in(resp_tag), .write_in(resp_write),
      .err_load, .err_in, .resp_fire,
      .state, .hrdata_q, .buf_data,
      .ahb, .hready, .bready, .rready,
      .bvalid, .bid, .bresp,
      .rvalid, .rid, .rresp, .rdata
   );

endmodule

/* source/axi_ahb_pkg.sv */
// ******************************
// AXI4 to AHB-Lite bridge types
// Channel structs, bus command, byte plan,
// response data views and FSM states
// ******************************
package axi_ahb_pkg;
`include "axi_ahb_settings.svh"

   typedef struct packed {
      logic [`AXI_TAG_W-1:0]  id;
      logic [`BUS_ADDR_W-1:0] addr;
      logic [2:0]             size;
   } axi_aw_t;

   typedef struct packed {
      logic [`BUS_DATA_W-1:0] data;
      logic [`BUS_STRB_W-1:0] strb;
   } axi_w_t;

   typedef struct packed {
      logic [`AXI_TAG_W-1:0]  id;
      logic [`BUS_ADDR_W-1:0] addr;
      logic [2:0]             size;
   } axi_ar_t;

   typedef struct packed {
      logic                   write;
      logic [`AXI_TAG_W-1:0]  tag;
      logic [`BUS_ADDR_W-1:0] addr;
      logic [2:0]             size;
      logic [`BUS_DATA_W-1:0] wdata;
      logic [`BUS_STRB_W-1:0] byteen;
   } bus_cmd_t;

   typedef struct packed {
      logic [`BUS_ADDR_W-1:0] haddr;
      logic [2:0]             hsize;
      logic [1:0]             htrans;
      logic                   hwrite;
   } ahb_req_t;

   typedef struct packed {
      logic       aligned;     // One transfer covers all strobes
      logic [1:0] size;
      logic [2:0] offset;
      logic [2:0] next_ptr;
      logic       last;        // No strobe left past ptr
   } byte_plan_t;

   // Read data, or the failing write address twice
   typedef union packed {
      logic [`BUS_DATA_W-1:0] rdata;
      struct packed {
         logic [`BUS_ADDR_W-1:0] addr_hi;
         logic [`BUS_ADDR_W-1:0] addr_lo;
      } err;
   } resp_data_u;

   typedef enum logic [2:0] {IDLE, CMD_RD, DATA_RD, CMD_WR, DATA_WR, DONE} xfer_state_e;

endpackage

/* source/axi_ahb_settings.svh */
// ******************************
// AXI4 to AHB-Lite bridge settings
// Bus widths, tag width, AHB and AXI codes
// ******************************
`ifndef AXI_AHB_SETTINGS_SVH
`define AXI_AHB_SETTINGS_SVH

`define AXI_TAG_W     1
`define BUS_ADDR_W    32
`define BUS_DATA_W    64
`define BUS_STRB_W    8

// AHB htrans encodings, only two are ever driven
`define HTRANS_IDLE   2'b00
`define HTRANS_NONSEQ 2'b10

`define RESP_OKAY     2'b00
`define RESP_SLVERR   2'b10

`endif

/* source/axi_resp_gen.sv */
// ******************************
// AXI response generator
// Response tag and error flags, last write
// address, and B / R channel drive
// ******************************
`timescale 1ns/1ps
`include "axi_ahb_settings.svh"

module axi_resp_gen import axi_ahb_pkg::*; (
   input  logic                   ahbm_clk,
   input  logic                   rst,
   input  logic                   resp_load,
   input  logic [`AXI_TAG_W-1:0]  tag_in,
   input  logic                   write_in,
   input  logic                   err_load,
   input  logic                   err_in,
   input  logic                   resp_fire,
   input  xfer_state_e            state,
   input  logic [`BUS_DATA_W-1:0] hrdata_q,
   input  logic [`BUS_DATA_W-1:0] buf_data,
   input  ahb_req_t               ahb,
   input  logic                   hready,
   input  logic                   bready,
   input  logic                   rready,
   output logic                   bvalid,
   output logic [`AXI_TAG_W-1:0]  bid,
   output logic [1:0]             bresp,
   output logic                   rvalid,
   output logic [`AXI_TAG_W-1:0]  rid,
   output logic [1:0]             rresp,
   output logic [`BUS_DATA_W-1:0] rdata
);

   logic [`AXI_TAG_W-1:0]  tag_q;
   logic                   write_q, err_q;
   logic [`BUS_ADDR_W-1:0] last_addr;
   logic                   last_addr_en, taken;
   resp_data_u             data;

   // Accepted write address phase
   assign last_addr_en = (ahb.htrans != `HTRANS_IDLE) & hready & ahb.hwrite;

   always_ff @(posedge ahbm_clk) begin
      if (rst) begin
         write_q <= 1'b0;
         err_q   <= 1'b0;
      end else begin
         if (resp_load) write_q <= write_in;
         if (err_load)  err_q   <= err_in;
      end
   end

   always_ff @(posedge ahbm_clk) begin
      if (resp_load)    tag_q     <= tag_in;
      if (last_addr_en) last_addr <= ahb.haddr;
   end

   always_comb begin
      if (err_q) begin
         data.err.addr_hi = last_addr;
         data.err.addr_lo = last_addr;
      end else begin
         data.rdata = (state == DONE) ? buf_data : hrdata_q;
      end
   end

   assign taken  = resp_fire & bready & rready;  // Needs both channels ready
   assign bvalid = taken & write_q;
   assign rvalid = taken & ~write_q;
   assign bid    = tag_q;
   assign rid    = tag_q;
   assign bresp  = err_q ? `RESP_SLVERR : `RESP_OKAY;
   assign rresp  = err_q ? `RESP_SLVERR : `RESP_OKAY;
   assign rdata  = data.rdata;

endmodule

/* source/axi_wr_gather.sv */
// ******************************
// Write gather buffer
// Holds one AW and one W beat and picks the
// next command, write before read
// ******************************
`timescale 1ns/1ps
`include "axi_ahb_settings.svh"

module axi_wr_gather import axi_ahb_pkg::*; (
   input  logic     ahbm_clk,
   input  logic     rst,
   input  logic     awvalid,
   output logic     awready,
   input  axi_aw_t  aw,
   input  logic     wvalid,
   output logic     wready,
   input  axi_w_t   w,
   input  logic     arvalid,
   output logic     arready,
   input  axi_ar_t  ar,
   output logic     cmd_valid,
   input  logic     cmd_ready,
   output bus_cmd_t cmd
);

   logic    aw_vld, w_vld;
   logic    aw_en, w_en;
   logic    wr_cmd, wr_sent;
   axi_aw_t aw_q;
   axi_w_t  w_q;

   assign wr_cmd  = aw_vld & w_vld;            // Both halves stored
   assign wr_sent = wr_cmd & cmd_ready;

   assign awready = ~(aw_vld & ~wr_sent) & cmd_ready;
   assign wready  = ~(w_vld & ~wr_sent) & cmd_ready;
   assign arready = ~wr_cmd & cmd_ready;

   assign aw_en = awvalid & awready;
   assign w_en  = wvalid & wready;

   always_ff @(posedge ahbm_clk) begin
      if (rst) begin
         aw_vld <= 1'b0;
         w_vld  <= 1'b0;
      end else begin
         aw_vld <= aw_en | (aw_vld & ~wr_sent);   // A new beat refills the slot
         w_vld  <= w_en | (w_vld & ~wr_sent);
      end
   end

   always_ff @(posedge ahbm_clk) begin
      if (aw_en) aw_q <= aw;
      if (w_en)  w_q  <= w;
   end

   // ******************************
   // Command select
   // ******************************
   assign cmd_valid = wr_cmd | arvalid;

   always_comb begin
      cmd.write  = wr_cmd;
      cmd.tag    = wr_cmd ? aw_q.id : ar.id;
      cmd.addr   = wr_cmd ? aw_q.addr : ar.addr;
      cmd.size   = wr_cmd ? aw_q.size : ar.size;
      cmd.wdata  = w_q.data;
      cmd.byteen = w_q.strb;
   end

   // Stored address is kept until it goes out
   aw_hold_a: assert property (@(posedge ahbm_clk) disable iff (rst)
      aw_vld && !wr_sent |=> $stable(aw_q));

endmodule

/* src.f */
+incdir+source
source/axi_ahb_pkg.sv
source/axi_wr_gather.sv
source/ahb_byte_planner.sv
source/ahb_xfer_fsm.sv
source/axi_resp_gen.sv
source/axi4_to_ahb.sv
tb/tb_clkgen.sv
tb/ahb_mem_model.sv
tb/axi4_to_ahb_tb.sv

/* tb/ahb_mem_model.sv */
// ******************************
// AHB-Lite slave memory
// Random 0..2 wait states, two-cycle error
// response in the top 4 KB, transfer log
// ******************************
`timescale 1ns/1ps
`include "axi_ahb_settings.svh"

module ahb_mem_model import axi_ahb_pkg::*; (
   input  logic                   ahbm_clk,
   input  logic                   rst,
   input  ahb_req_t               ahb,
   input  logic [`BUS_DATA_W-1:0] hwdata,
   output logic [`BUS_DATA_W-1:0] hrdata,
   output logic                   hready,
   output logic                   hresp
);

   localparam logic [31:0] ERR_BASE = 32'hffff_f000;

   logic [63:0] mem [512];
   logic        dp_active, dp_write, dp_err;
   logic [31:0] dp_addr;
   logic [2:0]  dp_size;
   logic [1:0]  waits;
   int          wait_draw;
   int          xfer_count;
   logic [2:0]  off_log [256];                 // Byte offset per transfer
   logic [2:0]  size_log [256];

   // Fill pattern built from the byte address of each doubleword
   initial begin
      for (int i = 0; i < 512; i++) begin
         mem[i] = {~(32'(i) << 3), 32'(i) << 3};
      end
   end

   assign hrdata = mem[dp_addr[11:3]];

   always @(posedge ahbm_clk) begin
      if (rst) begin
         hready     <= 1'b1;
         hresp      <= 1'b0;
         dp_active  <= 1'b0;
         dp_err     <= 1'b0;
         xfer_count <= 0;
      end else begin
         // Data phase ends on this edge
         if (hready && dp_active) begin
            dp_active <= 1'b0;
            hresp     <= 1'b0;
            if (dp_write && !dp_err) begin
               for (int k = 0; k < 8; k++) begin
                  if (k >= int'(dp_addr[2:0]) && k < int'(dp_addr[2:0]) + (1 << dp_size)) begin
                     mem[dp_addr[11:3]][8*k +: 8] <= hwdata[8*k +: 8];
                  end
               end
            end
         end
         // ******************************
         // Address phase accept
         // ******************************
         if (hready && ahb.htrans[1]) begin
            dp_active                <= 1'b1;
            dp_addr                  <= ahb.haddr;
            dp_size                  <= ahb.hsize;
            dp_write                 <= ahb.hwrite;
            off_log[xfer_count[7:0]]  <= ahb.haddr[2:0];
            size_log[xfer_count[7:0]] <= ahb.hsize;
            xfer_count               <= xfer_count + 1;
            if (ahb.haddr >= ERR_BASE) begin
               dp_err <= 1'b1;
               hready <= 1'b0;                 // First error cycle
               hresp  <= 1'b1;
            end else begin
               wait_draw = $urandom_range(2, 0);
               dp_err <= 1'b0;
               waits  <= 2'(wait_draw);
               hready <= (wait_draw == 0);
               hresp  <= 1'b0;
            end
         end else if (dp_active && !hready) begin
            if (dp_err) begin
               hready <= 1'b1;                 // Second error cycle, hresp held
            end else begin
               waits  <= waits - 2'd1;
               hready <= (waits == 2'd1);
            end
         end
      end
   end

endmodule

/* tb/axi4_to_ahb_tb.sv */
// ******************************
// AXI4 to AHB-Lite bridge testbench
// Table of writes and reads with expected
// responses, data and AHB transfer counts
// ******************************
`timescale 1ns/1ps
`include "axi_ahb_settings.svh"

module axi4_to_ahb_tb import axi_ahb_pkg::*; ();

   localparam int OP_WR    = 0;
   localparam int OP_RD    = 1;
   localparam int OP_WR_BP = 2;                // Write with bready held low
   localparam int N_VEC    = 14;

   typedef struct {
      int          op;
      logic [31:0] addr;
      logic [63:0] data;
      logic [7:0]  strb;
      logic [1:0]  resp;
      logic [63:0] rdat;
      int          cnt;
   } vec_t;

   vec_t                   vec [N_VEC];
   logic                   ahbm_clk, rst;
   logic                   awvalid, awready, wvalid, wready, arvalid, arready;
   axi_aw_t                aw;
   axi_w_t                 w;
   axi_ar_t                ar;
   logic                   bvalid, bready, rvalid, rready;
   logic [`AXI_TAG_W-1:0]  bid, rid;
   logic [1:0]             bresp, rresp;
   logic [`BUS_DATA_W-1:0] rdata, hwdata, hrdata;
   ahb_req_t               ahb;
   logic                   hready, hresp;
   int                     errors;

   tb_clkgen u_clkgen (.ahbm_clk, .rst);

   axi4_to_ahb u_axi4_to_ahb (
      .ahbm_clk, .rst,
      .awvalid, .awready, .aw, .wvalid, .wready, .w,
      .bvalid, .bready, .bid, .bresp,
      .arvalid, .arready, .ar,
      .rvalid, .rready, .rid, .rresp, .rdata,
      .ahb, .hwdata, .hrdata, .hready, .hresp
   );

   ahb_mem_model u_mem (.ahbm_clk, .rst, .ahb, .hwdata, .hrdata, .hready, .hresp);

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         errors++;
         $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
         $display("STATUS: FAIL");
         $fatal(1, "value mismatch");
      end
   endtask

   // AHB size that covers every strobed byte in one transfer
   function automatic logic [2:0] expect_hsize(input logic [7:0] s);
      int n;
      n = $countones(s);
      return (n == 8) ? 3'd3 : (n == 4) ? 3'd2 : (n == 2) ? 3'd1 : 3'd0;
   endfunction

   function automatic logic [2:0] nth_set_bit(input logic [7:0] s, input int n);
      int seen;
      seen = 0;
      for (int k = 0; k < 8; k++) begin
         if (s[k]) begin
            if (seen == n) return 3'(k);
            seen++;
         end
      end
      return 3'd0;
   endfunction

   task automatic load_vectors();
      vec[0]  = '{OP_WR, 32'h0000_1000, 64'h1122_3344_5566_7788, 8'hff, `RESP_OKAY, '0, 1};
      vec[1]  = '{OP_RD, 32'h0000_1000, '0, 8'h00, `RESP_OKAY, 64'h1122_3344_5566_7788, 1};
      vec[2]  = '{OP_WR, 32'h0000_1000, {8{8'haa}}, 8'h0c, `RESP_OKAY, '0, 1};
      vec[3]  = '{OP_RD, 32'h0000_1000, '0, 8'h00, `RESP_OKAY, 64'h1122_3344_aaaa_7788, 1};
      vec[4]  = '{OP_WR, 32'h0000_1000, {8{8'hbb}}, 8'h30, `RESP_OKAY, '0, 1};
      vec[5]  = '{OP_RD, 32'h0000_1000, '0, 8'h00, `RESP_OKAY, 64'h1122_bbbb_aaaa_7788, 1};
      vec[6]  = '{OP_WR, 32'h0000_1000, {8{8'hcc}}, 8'hf0, `RESP_OKAY, '0, 1};
      vec[7]  = '{OP_RD, 32'h0000_1000, '0, 8'h00, `RESP_OKAY, 64'hcccc_cccc_aaaa_7788, 1};
      vec[8]  = '{OP_WR, 32'h0000_1000, {8{8'hdd}}, 8'h5a, `RESP_OKAY, '0, 4};
      vec[9]  = '{OP_RD, 32'h0000_1000, '0, 8'h00, `RESP_OKAY, 64'hccdd_ccdd_ddaa_dd88, 1};
      vec[10] = '{OP_WR, 32'hffff_f100, 64'h0123_4567_89ab_cdef, 8'hff, `RESP_SLVERR, '0, 1};
      vec[11] = '{OP_RD, 32'hffff_f200, '0, 8'h00, `RESP_SLVERR, {2{32'hffff_f100}}, 1};
      vec[12] = '{OP_WR_BP, 32'h0000_1008, {4{16'h5a5a}}, 8'hff, `RESP_OKAY, '0, 1};
      vec[13] = '{OP_RD, 32'h0000_1008, '0, 8'h00, `RESP_OKAY, {4{16'h5a5a}}, 1};
   endtask

   task automatic send_write(input logic [31:0] addr, input logic [63:0] data,
                             input logic [7:0] strb, input logic [`AXI_TAG_W-1:0] id);
      logic aw_hs, w_hs;
      @(posedge ahbm_clk);
      #1;
      aw      = '{id: id, addr: addr, size: 3'd3};
      w       = '{data: data, strb: strb};
      awvalid = 1'b1;
      wvalid  = 1'b1;
      while (awvalid || wvalid) begin
         @(negedge ahbm_clk);
         aw_hs = awvalid & awready;
         w_hs  = wvalid & wready;
         @(posedge ahbm_clk);
         #1;
         if (aw_hs) awvalid = 1'b0;
         if (w_hs)  wvalid  = 1'b0;
      end
   endtask

   task automatic send_read(input logic [31:0] addr, input logic [`AXI_TAG_W-1:0] id);
      logic ar_hs;
      @(posedge ahbm_clk);
      #1;
      ar      = '{id: id, addr: addr, size: 3'd3};
      arvalid = 1'b1;
      while (arvalid) begin
         @(negedge ahbm_clk);
         ar_hs = arvalid & arready;
         @(posedge ahbm_clk);
         #1;
         if (ar_hs) arvalid = 1'b0;
      end
   endtask

   // ******************************
   // One table entry
   // ******************************
   task automatic run_vector(input int idx);
      vec_t                  v;
      logic [`AXI_TAG_W-1:0] id;
      int                    base;
      v    = vec[idx];
      id   = `AXI_TAG_W'(idx / 2);             // Both tag values on both channels
      base = u_mem.xfer_count;
      if (v.op == OP_RD) begin
         send_read(v.addr, id);
         do @(negedge ahbm_clk); while (!rvalid);
         check_value("rid", 64'(rid), 64'(id));
         check_value("rresp", 64'(rresp), 64'(v.resp));
         check_value("rdata", rdata, v.rdat);
      end else begin
         if (v.op == OP_WR_BP) begin
            @(posedge ahbm_clk);
            #1 bready = 1'b0;
         end
         send_write(v.addr, v.data, v.strb, id);
         if (v.op == OP_WR_BP) begin
            repeat (20) begin
               @(negedge ahbm_clk);
               check_value("bvalid", 64'(bvalid), 64'd0);
               check_value("arready", 64'(arready), 64'd0);
            end
            @(posedge ahbm_clk);
            #1 bready = 1'b1;
         end
         do @(negedge ahbm_clk); while (!bvalid);
         check_value("bid", 64'(bid), 64'(id));
         check_value("bresp", 64'(bresp), 64'(v.resp));
      end
      check_value("xfer_count", 64'(u_mem.xfer_count - base), 64'(v.cnt));
      if (v.op != OP_RD && v.cnt == 1) begin
         check_value("hsize", 64'(u_mem.size_log[base]), 64'(expect_hsize(v.strb)));
         check_value("haddr_off", 64'(u_mem.off_log[base]), 64'(nth_set_bit(v.strb, 0)));
      end else if (v.op != OP_RD) begin
         for (int k = 0; k < v.cnt; k++) begin
            check_value("hsize", 64'(u_mem.size_log[base + k]), 64'd0);
            check_value("haddr_off", 64'(u_mem.off_log[base + k]),
                        64'(nth_set_bit(v.strb, k)));
         end
      end
      repeat (2) @(posedge ahbm_clk);
   endtask

   initial begin
      #(N_VEC * 200 * 10 + 100);
      $display("Timeout: the bridge stopped responding before the table finished");
      $display("STATUS: FAIL");
      $fatal(1, "watchdog expired");
   end

   initial begin
      void'($urandom(60548));
      errors  = 0;
      awvalid = 1'b0;
      wvalid  = 1'b0;
      arvalid = 1'b0;
      aw      = '0;
      w       = '0;
      ar      = '0;
      bready  = 1'b1;
      rready  = 1'b1;
      load_vectors();
      do @(negedge ahbm_clk); while (rst);
      check_value("htrans", 64'(ahb.htrans), 64'(`HTRANS_IDLE));  // Idle after reset
      check_value("bvalid", 64'(bvalid), 64'd0);
      check_value("rvalid", 64'(rvalid), 64'd0);
      check_value("awready", 64'(awready), 64'd1);
      check_value("wready", 64'(wready), 64'd1);
      check_value("arready", 64'(arready), 64'd1);
      for (int i = 0; i < N_VEC; i++) begin
         run_vector(i);
      end
      if (errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

/* tb/tb_clkgen.sv */
// ******************************
// Testbench clock and reset
// 10 ns clock, reset held for 2 cycles
// ******************************
`timescale 1ns/1ps

module tb_clkgen (
   output logic ahbm_clk,
   output logic rst
);

   initial ahbm_clk = 1'b0;
   always #5 ahbm_clk = ~ahbm_clk;

   initial begin
      rst = 1'b1;
      repeat (2) @(posedge ahbm_clk);
      #1 rst = 1'b0;                           // Released off the edge
   end

endmodule
